// File: Bender.yml
package:
  name: conv_pad

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pad_pkg.sv
      - pad_filter.sv
      - psum_combiner.sv
      - credit_fifo.sv
      - conv_pad_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_conv_pad.sv

// File: conv_pad_top.sv
`timescale 1ns/1ps
`include "pad_defines.svh"

module conv_pad_top
    import pad_pkg::*;
(
    input  logic           aclk,
    input  logic           reset,
    input  logic           in_valid,
    input  pad_in_beat_t   in_beat,
    output logic           in_credit,
    output logic           out_valid,
    output pad_out_beat_t  out_beat,
    input  logic           out_credit
);
    pad_user_t [`PAD_MEMBERS-1:0] user_rep;                // Same side-band on every datapath
    logic      [`PAD_MEMBERS-1:0] mask_full;
    logic      [`PAD_MEMBERS-1:0] mask_partial;
    logic      [`PAD_MEMBERS-1:0] is_left_col;
    logic      [`PAD_MEMBERS-1:0] is_right_col;
    logic                         valid_q;                 // Registered beat is ready for the FIFO
    pad_out_beat_t                beat_q;

    assign user_rep = {`PAD_MEMBERS{in_beat.user}};

    pad_filter u_filter (
        .aclk         (aclk),
        .reset        (reset),
        .valid        (in_valid),
        .user         (user_rep),
        .mask_full    (mask_full),
        .mask_partial (mask_partial),
        .is_left_col  (is_left_col),
        .is_right_col (is_right_col)
    );

    psum_combiner u_combiner (
        .aclk         (aclk),
        .reset        (reset),
        .valid        (in_valid),
        .beat         (in_beat),
        .mask_full    (mask_full),
        .mask_partial (mask_partial),
        .is_left_col  (is_left_col),
        .is_right_col (is_right_col),
        .valid_q      (valid_q),
        .beat_q       (beat_q)
    );

    credit_fifo #(
        .item_t (pad_out_beat_t)
    ) u_fifo (
        .aclk       (aclk),
        .reset      (reset),
        .push       (valid_q),
        .push_item  (beat_q),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_item   (out_beat),
        .out_credit (out_credit)
    );

endmodule

// File: credit_fifo.sv
`timescale 1ns/1ps
`include "pad_defines.svh"

module credit_fifo
    import pad_pkg::*;
#(
    parameter type item_t = pad_out_beat_t
)(
    input  logic   aclk,
    input  logic   reset,
    input  logic   push,
    input  item_t  push_item,
    output logic   in_credit,
    output logic   out_valid,
    output item_t  out_item,
    input  logic   out_credit
);
    localparam int DEPTH = `PAD_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];                         // Circular storage for the beats
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;                                // Entries held right now
    logic [CNT_W-1:0] spent;                               // Output credits used and not returned
    logic             empty;
    logic             full;
    logic             has_credit;
    logic             pop;

    assign empty      = (fill == '0);
    assign full       = (fill == CNT_W'(DEPTH));
    assign has_credit = (spent != CNT_W'(DEPTH));          // Sink still has room downstream
    assign pop        = !empty && has_credit;

    assign out_valid  = pop;                               // Each pop is one beat to the sink
    assign in_credit  = pop;                               // Freed entry goes back upstream
    assign out_item   = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            spent  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill  <= fill + CNT_W'(push) - CNT_W'(pop);
            spent <= spent + CNT_W'(pop) - CNT_W'(out_credit);  // Sink returns one per cycle
        end
    end

    // Upstream credits cover every free entry, so a push never meets a full buffer
    a_no_overflow : assert property (@(posedge aclk) disable iff (reset)
        push |-> !full)
        else $error("credit_fifo push while full");

    // A returned credit must match one that was spent earlier
    a_credit_bound : assert property (@(posedge aclk) disable iff (reset)
        out_credit |-> (spent != '0) || pop)
        else $error("credit_fifo output credits above the limit");

endmodule

// File: pad_defines.svh
`ifndef PAD_DEFINES_SVH
`define PAD_DEFINES_SVH

// Geometry of the datapath row

`define PAD_MEMBERS        8    // Number of parallel datapaths in one row
`define PAD_KERNEL_W_MAX   7    // Largest odd kernel width the lookup logic is built for
`define PAD_KW_BITS        3    // Width of the kernel width code in the side-band

// Word widths

`define PAD_DATA_W         16   // Signed partial sum delivered by each datapath
`define PAD_SUM_W          17   // Signed merged sum, one guard bit for the neighbour add

// Flow control

`define PAD_CREDITS        4    // FIFO depth and the starting credit count on both sides

`endif

// File: pad_filter.sv
`timescale 1ns/1ps
`include "pad_defines.svh"

module pad_filter
    import pad_pkg::*;
(
    input  logic                             aclk,
    input  logic                             reset,
    input  logic                             valid,
    input  pad_user_t [`PAD_MEMBERS-1:0]     user,
    output logic      [`PAD_MEMBERS-1:0]     mask_full,
    output logic      [`PAD_MEMBERS-1:0]     mask_partial,
    output logic      [`PAD_MEMBERS-1:0]     is_left_col,
    output logic      [`PAD_MEMBERS-1:0]     is_right_col
);
    localparam int MEMBERS  = `PAD_MEMBERS;
    localparam int KW2_MAX  = `PAD_KERNEL_W_MAX / 2;   // Largest r for kw = 2r+1
    localparam int KW2_BITS = `PAD_KW_BITS - 1;

    logic [KW2_BITS-1:0] kw2       [MEMBERS];          // Selects the lookup table per datapath
    logic [KW2_MAX:0]    col_end   [MEMBERS];          // End taps with tap 0 tied low
    logic [KW2_MAX:0]    col_start [MEMBERS];          // Start taps with tap 0 tied low
    logic [KW2_MAX:0]    lut_full  [MEMBERS];          // Full mask for every kernel width
    logic [KW2_MAX:0]    lut_stop  [MEMBERS-1:1];      // Partial block for every kernel width

    // Column tracking per datapath

    for (genvar m = 0; m < MEMBERS; m++) begin : g_col
        logic [KW2_MAX:1] end_q;     // Delayed copies of cols_1_k2
        logic [KW2_MAX:1] start_q;   // Continues the end chain into the next row
        logic             left_q;    // Delayed start tap marks the left output column
        logic             step;      // Column boundary seen on this datapath

        assign kw2[m]       = user[m].kernel_w[`PAD_KW_BITS-1:1];  // Halved width, 7 gives 3
        assign step         = valid && user[m].cin_last;            // Advance once per column
        assign col_end[m]   = {end_q, 1'b0};
        assign col_start[m] = {start_q, 1'b0};

        always_ff @(posedge aclk) begin
            if (reset) begin
                end_q   <= '0;                             // No row end pending after reset
                start_q <= KW2_MAX'(1);                    // First column counts as a row start
                left_q  <= 1'b1;                           // First column is a left column
            end else if (step) begin
                end_q[1]   <= user[m].cols_1_k2;           // New end marker enters tap 1
                start_q[1] <= col_end[m][kw2[m]];          // Row end of this kernel starts a row
                for (int k = 2; k <= KW2_MAX; k++) begin
                    end_q[k]   <= end_q[k-1];
                    start_q[k] <= start_q[k-1];
                end
                left_q <= col_start[m][kw2[m]];            // Output starts k/2 columns late
            end
        end

        // Width 1 has no edges, so both flags stay low for it
        assign is_left_col[m]  = left_q && (kw2[m] != '0);
        assign is_right_col[m] = (m == kw2[m]) && col_end[m][kw2[m]];

        a_kernel_odd : assert property (@(posedge aclk) disable iff (reset)
            valid |-> user[m].kernel_w[0])
            else $error("pad_filter even kernel width on datapath %0d", m);
    end

    // Full mask lookup

    for (genvar m = 0; m < MEMBERS; m++) begin : g_full
        assign lut_full[m][0] = 1'b1;                      // Width 1 keeps every datapath

        for (genvar r = 1; r <= KW2_MAX; r++) begin : g_kw
            localparam int KW     = 2 * r + 1;
            localparam int POS    = m % KW;                // Position inside the kernel group
            localparam bit UNUSED = m >= (MEMBERS / KW) * KW;

            logic start_cols;
            logic mid_open;
            logic last_open;

            assign start_cols = |col_start[m][r:1];        // Inside the first k/2 columns
            assign mid_open   = (POS == KW - 1) && !start_cols;   // Complete group in the middle
            assign last_open  = col_end[m][r] && (POS >= r) && !UNUSED;  // Padded tail at row end
            assign lut_full[m][r] = mid_open || last_open;
        end

        assign mask_full[m] = lut_full[m][kw2[m]] || user[m].is_config;
    end

    // Partial mask lookup

    assign mask_partial[0] = 1'b0;                         // Datapath 0 has no left neighbour

    for (genvar m = 1; m < MEMBERS; m++) begin : g_part
        assign lut_stop[m][0] = 1'b0;                      // Width 1 leaves the partial mask open

        for (genvar r = 1; r <= KW2_MAX; r++) begin : g_kw
            localparam int KW     = 2 * r + 1;
            localparam int POS    = m % KW;
            localparam bit UNUSED = m >= (MEMBERS / KW) * KW;

            logic end_partial;

            if (POS > r) begin : g_tail
                assign end_partial = col_end[m][r];        // Only the last column cuts this chain
            end else begin : g_tri
                assign end_partial = |col_end[m][r:POS];   // Triangle of cuts near the row end
            end

            assign lut_stop[m][r] = end_partial || UNUSED;
        end

        assign mask_partial[m] = !lut_stop[m][kw2[m]];
    end

endmodule

// File: pad_pkg.sv
`include "pad_defines.svh"

package pad_pkg;

    // One signed partial sum as it leaves a datapath
    typedef logic signed [`PAD_DATA_W-1:0] pad_psum_t;

    // One signed merged sum after the neighbour add
    typedef logic signed [`PAD_SUM_W-1:0] pad_sum_t;

    // Side-band that travels with every beat
    typedef struct packed {
        logic                    is_config;  // Configuration beat, passes with the full mask open
        logic                    cin_last;   // Last input channel of the current column
        logic                    cols_1_k2;  // Rises k/2 columns before the last column
        logic [`PAD_KW_BITS-1:0] kernel_w;   // Odd kernel width, 1 means no padding
    } pad_user_t;

    // Beat from the datapath row into the padding stage
    typedef struct packed {
        pad_user_t                      user;   // Shared side-band of the row
        pad_psum_t [`PAD_MEMBERS-1:0]   psum;   // One partial sum per datapath
    } pad_in_beat_t;

    // Beat from the padding stage towards the sink
    typedef struct packed {
        pad_sum_t [`PAD_MEMBERS-1:0]    sum;        // Merged sums, zero where keep is clear
        logic     [`PAD_MEMBERS-1:0]    keep;       // Copy of the full mask
        logic     [`PAD_MEMBERS-1:0]    left_col;   // First output column flags
        logic     [`PAD_MEMBERS-1:0]    right_col;  // Last output column flags
    } pad_out_beat_t;

endpackage

// File: psum_combiner.sv
`timescale 1ns/1ps
`include "pad_defines.svh"

module psum_combiner
    import pad_pkg::*;
(
    input  logic                         aclk,
    input  logic                         reset,
    input  logic                         valid,
    input  pad_in_beat_t                 beat,
    input  logic [`PAD_MEMBERS-1:0]      mask_full,
    input  logic [`PAD_MEMBERS-1:0]      mask_partial,
    input  logic [`PAD_MEMBERS-1:0]      is_left_col,
    input  logic [`PAD_MEMBERS-1:0]      is_right_col,
    output logic                         valid_q,
    output pad_out_beat_t                beat_q
);
    localparam int MEMBERS = `PAD_MEMBERS;
    localparam int DATA_W  = `PAD_DATA_W;
    localparam int SUM_W   = `PAD_SUM_W;

    pad_sum_t [MEMBERS-1:0] sum_d;                         // Masked sums before the register

    // Neighbour merge per datapath

    for (genvar m = 0; m < MEMBERS; m++) begin : g_sum
        logic signed [DATA_W-1:0] own_w;                   // This datapath's partial sum
        logic signed [DATA_W-1:0] nbr_w;                   // Left neighbour or zero
        logic signed [SUM_W-1:0]  sum_full;                // Merged value before the keep mask

        assign own_w = beat.psum[m];

        if (m == 0) begin : g_first
            assign nbr_w = '0;                             // Nothing lies left of datapath 0
        end else begin : g_next
            assign nbr_w = mask_partial[m] ? beat.psum[m-1] : '0;
        end

        // Both operands are signed, so they are sign extended to the sum width
        assign sum_full = own_w + nbr_w;
        assign sum_d[m] = mask_full[m] ? sum_full : '0;    // Closed datapaths emit zero
    end

    // Output pipeline register

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid;                              // One cycle behind the input beat
        end
    end

    always_ff @(posedge aclk) begin
        if (valid) begin
            beat_q.sum       <= sum_d;
            beat_q.keep      <= mask_full;                 // Sink uses keep to drop padding words
            beat_q.left_col  <= is_left_col;
            beat_q.right_col <= is_right_col;
        end
    end

    // The filter must never ask datapath 0 to borrow from a missing neighbour
    a_no_partial_zero : assert property (@(posedge aclk) disable iff (reset)
        valid |-> !mask_partial[0])
        else $error("psum_combiner partial mask set on datapath 0");

endmodule

// File: src.f
+incdir+.
pad_pkg.sv
pad_filter.sv
psum_combiner.sv
credit_fifo.sv
conv_pad_top.sv
tb_conv_pad.sv

// File: tb_conv_pad.sv
`timescale 1ns/1ps
`include "pad_defines.svh"

module tb_conv_pad
    import pad_pkg::*;
();
    localparam int          MEMBERS   = `PAD_MEMBERS;
    localparam int          CREDITS   = `PAD_CREDITS;
    localparam int          RESET_CYC = 10;
    localparam logic [31:0] SEED      = 32'h8fd6_4ee5;

    logic          aclk;
    logic          reset;
    logic          in_valid;
    pad_in_beat_t  in_beat;
    logic          in_credit;
    logic          out_valid;
    pad_out_beat_t out_beat;
    logic          out_credit = 1'b0;                 // Sink holds its credits until a beat lands

    pad_in_beat_t  in_q[$];                           // Beats still waiting for an upstream credit
    pad_out_beat_t exp_q[$];                          // Expected results in output order
    int            due_q[$];                          // Cycles at which the sink returns a credit
    int            n_in        = 0;
    int            n_exp       = 0;
    int            matched     = 0;                   // Results checked so far
    int            credits     = CREDITS;             // Upstream credits held by the testbench
    int            in_flight   = 0;                   // Beats sent and not yet credited back
    int            sink_credits = CREDITS;            // Output credits the DUT may still spend
    int            cycle       = 0;
    int            cycle_limit = 0;

    initial begin
        aclk = 1'b0;
    end

    always #2 aclk = ~aclk;                           // 4 ns clock period

    conv_pad_top dut0 (
        .aclk       (aclk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic read_hex(input int fd, output logic [31:0] value);
        int code;
        code = $fscanf(fd, "%h", value);
        if (code != 1) begin
            stop_with_failure("Stimulus file holds a short or malformed record");
        end
    endtask

    task automatic load_stim();
        int            fd;
        int            code;
        logic [63:0]   tag;
        logic [1023:0] rest;
        logic [31:0]   v;
        pad_in_beat_t  in_rec;
        pad_out_beat_t exp_rec;

        fd = $fopen("tb_conv_pad_stim.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open tb_conv_pad_stim.txt for reading");
        end
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);              // Rest of a column description line
            end else if (tag == "I") begin
                read_hex(fd, v);
                in_rec.user.is_config = v[0];
                read_hex(fd, v);
                in_rec.user.cin_last = v[0];
                read_hex(fd, v);
                in_rec.user.cols_1_k2 = v[0];
                read_hex(fd, v);
                in_rec.user.kernel_w = v[`PAD_KW_BITS-1:0];
                for (int m = 0; m < MEMBERS; m++) begin
                    read_hex(fd, v);
                    in_rec.psum[m] = v[`PAD_DATA_W-1:0];
                end
                in_q.push_back(in_rec);
            end else if (tag == "E") begin
                for (int m = 0; m < MEMBERS; m++) begin
                    read_hex(fd, v);
                    exp_rec.sum[m] = v[`PAD_SUM_W-1:0];
                end
                read_hex(fd, v);
                exp_rec.keep = v[MEMBERS-1:0];
                read_hex(fd, v);
                exp_rec.left_col = v[MEMBERS-1:0];
                read_hex(fd, v);
                exp_rec.right_col = v[MEMBERS-1:0];
                exp_q.push_back(exp_rec);
            end else begin
                stop_with_failure("Stimulus file holds a record with an unknown tag");
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        n_in  = in_q.size();
        n_exp = exp_q.size();
    endtask

    task automatic check_sums(input pad_sum_t [MEMBERS-1:0] got,
                              input pad_sum_t [MEMBERS-1:0] want,
                              input int idx);
        for (int m = 0; m < MEMBERS; m++) begin
            if (got[m] !== want[m]) begin
                stop_with_failure($sformatf("ERR t=%0t result %0d sum[%0d] is %h, expected %h",
                                            $time, idx, m, got[m], want[m]));
            end
        end
    endtask

    task automatic check_flags(input pad_out_beat_t got, input pad_out_beat_t want,
                               input int idx);
        if (got.keep !== want.keep) begin
            stop_with_failure($sformatf("ERR t=%0t result %0d keep is %h, expected %h",
                                        $time, idx, got.keep, want.keep));
        end
        if (got.left_col !== want.left_col) begin
            stop_with_failure($sformatf("ERR t=%0t result %0d left_col is %h, expected %h",
                                        $time, idx, got.left_col, want.left_col));
        end
        if (got.right_col !== want.right_col) begin
            stop_with_failure($sformatf("ERR t=%0t result %0d right_col is %h, expected %h",
                                        $time, idx, got.right_col, want.right_col));
        end
    endtask

    task automatic take_result(input pad_out_beat_t got);
        pad_out_beat_t want;
        if (exp_q.size() == 0) begin
            stop_with_failure("DUT sent an output beat after every expected result was used");
        end
        want = exp_q.pop_front();
        check_sums(got.sum, want.sum, matched);
        check_flags(got, want, matched);
        matched = matched + 1;
        due_q.push_back(cycle + int'($urandom % 4));  // Sink frees its slot 0 to 3 cycles later
    endtask

    // Outputs settle after the rising edge, so they are read on the falling edge
    always @(negedge aclk) begin
        if (!reset) begin
            if (in_credit) begin
                if (in_flight == 0) begin
                    stop_with_failure("DUT returned an input credit with no beat in flight");
                end
                credits   = credits + 1;
                in_flight = in_flight - 1;
            end
            if (out_valid) begin
                if (sink_credits == 0) begin
                    stop_with_failure("DUT sent an output beat without an output credit");
                end
                sink_credits = sink_credits - 1;
                take_result(out_beat);
            end
            if (out_credit) begin
                sink_credits = sink_credits + 1;      // DUT counts it at the next rising edge
            end
        end
    end

    always @(posedge aclk) begin
        if (reset) begin
            out_credit <= 1'b0;
        end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
            out_credit <= 1'b1;                       // At most one returned credit per cycle
            void'(due_q.pop_front());
        end else begin
            out_credit <= 1'b0;
        end
    end

    always @(posedge aclk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles with %0d of %0d results checked",
                                        cycle, matched, n_exp));
        end
    end

    initial begin
        void'($urandom(SEED));                        // Single seed for the whole run
        reset    = 1'b1;
        in_valid = 1'b0;
        in_beat  = '0;
        load_stim();
        cycle_limit = 20 * n_in + 100;                // Worst case per beat plus reset and drain
        repeat (RESET_CYC) @(posedge aclk);
        reset <= 1'b0;
        while (in_q.size() > 0) begin
            @(posedge aclk);
            if (credits > 0) begin
                in_valid  <= 1'b1;
                in_beat   <= in_q.pop_front();
                credits   = credits - 1;
                in_flight = in_flight + 1;
            end else begin
                in_valid <= 1'b0;                     // Out of credits, wait for in_credit
            end
        end
        @(posedge aclk);
        in_valid <= 1'b0;
        wait (matched == n_exp);
        repeat (2) @(posedge aclk);
        if (exp_q.size() == 0 && in_flight == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_failure("Run ended with results or upstream credits still outstanding");
        end
    end

endmodule

// File: tb_conv_pad_stim.txt
# I is_config cin_last cols_1_k2 kernel_w psum0 .. psum7, all hex
# E sum0 .. sum7 keep left_col right_col, all hex
I 0 1 0 3 0100 0101 0102 0103 0104 0105 0106 0107
E 00000 00000 00000 00000 00000 00000 00000 00000 00 ff 00
I 0 1 0 3 0200 0201 0202 0203 0204 0205 0206 0207
E 00000 00000 00403 00000 00000 00409 00000 00000 24 ff 00
I 0 1 0 3 0300 0301 0302 0303 0304 0305 0306 0307
E 00000 00000 00603 00000 00000 00609 00000 00000 24 00 00
I 1 0 0 3 0400 0401 0402 0403 0404 0405 0406 0407
E 00400 00801 00803 00805 00807 00809 00406 00407 ff 00 00
I 0 0 0 3 0500 0501 0502 0503 0504 0505 0506 0507
E 00000 00000 00a03 00000 00000 00a09 00000 00000 24 00 00
I 0 1 0 3 0600 0601 0602 0603 0604 0605 0606 0607
E 00000 00000 00c03 00000 00000 00c09 00000 00000 24 00 00
I 0 1 1 3 0700 0701 0702 0703 0704 0705 0706 0707
E 00000 00000 00e03 00000 00000 00e09 00000 00000 24 00 00
I 0 1 0 3 0800 0801 0802 0803 0804 0805 0806 0807
E 00000 00801 00802 00000 00804 00805 00000 00000 36 00 02
I 0 1 0 7 0900 0901 0902 0903 0904 0905 0906 0907
E 00000 00000 00000 00000 00000 00000 00000 00000 00 00 00
I 0 1 1 7 0a00 0a01 0a02 0a03 0a04 0a05 0a06 0a07
E 00000 00000 00000 00a03 00a04 00a05 00a06 00000 78 00 08
I 0 1 0 7 0b00 0b01 0b02 0b03 0b04 0b05 0b06 0b07
E 00000 00000 00000 00000 00000 00000 00000 00000 00 00 00
I 0 1 0 7 0c00 0c01 0c02 0c03 0c04 0c05 0c06 0c07
E 00000 00000 00000 00000 00000 00000 00000 00000 00 ff 00
I 0 1 0 7 0d00 0d01 0d02 0d03 0d04 0d05 0d06 0d07
E 00000 00000 00000 00d03 00d04 00d05 00d06 00000 78 00 08
I 0 1 0 5 0e00 0e01 0e02 0e03 0e04 0e05 0e06 0e07
E 00000 00000 00000 00000 00000 00000 00000 00000 00 ff 00
I 0 1 0 5 0f00 0f01 0f02 0f03 0f04 0f05 0f06 0f07
E 00000 00000 00000 00000 00000 00000 00000 00000 00 00 00
I 0 1 0 5 f000 f001 f002 f003 f004 f005 f006 f007
E 00000 00000 00000 00000 1e007 00000 00000 00000 10 ff 00
I 0 1 0 5 1100 1101 1102 1103 1104 1105 1106 1107
E 00000 00000 00000 00000 02207 00000 00000 00000 10 00 00
I 0 1 1 5 1200 1201 1202 1203 1204 1205 1206 1207
E 00000 00000 00000 00000 02407 00000 00000 00000 10 00 00
I 0 1 0 5 1300 1301 1302 1303 1304 1305 1306 1307
E 00000 00000 00000 00000 02607 00000 00000 00000 10 00 00
I 0 1 0 5 1400 1401 1402 1403 1404 1405 1406 1407
E 00000 00000 01402 01403 01404 00000 00000 00000 1c 00 04
